// ==== hw/kinpira_pkg.sv ====
package kinpira_pkg;

  // Default widths, the top level passes these down
  localparam int DWIDTH  = 16;
  localparam int IMGSIZE = 10;
  localparam int NETSIZE = 10;
  localparam int LWIDTH  = 8;

  localparam int REG_AWIDTH = 4;

  // Host register map
  typedef enum logic [REG_AWIDTH-1:0] {
    REG_WHICH      = 0,
    REG_REQ        = 1,
    REG_IN_OFFSET  = 2,
    REG_OUT_OFFSET = 3,
    REG_NET_OFFSET = 4,
    REG_TOTAL_OUT  = 5,
    REG_TOTAL_IN   = 6,
    // Read only, bit 0 ack, bits 2:1 registered which
    REG_STATUS     = 15
  } reg_addr_t;

  // Owner of the image memory
  typedef enum logic [1:0] {
    WHICH_HOST  = 0,
    WHICH_GOBOU = 1
  } which_t;

  // Dense engine states
  typedef enum logic [1:0] {
    S_IDLE,
    S_MAC,
    S_DRAIN,
    S_WRITE
  } gobou_state_t;

endpackage

// ==== hw/param_regs.sv ====
`timescale 1ns/10ps

module param_regs #(
  parameter int IMGSIZE = kinpira_pkg::IMGSIZE,
  parameter int NETSIZE = kinpira_pkg::NETSIZE,
  parameter int LWIDTH  = kinpira_pkg::LWIDTH
) (
  input  logic                               clk,
  input  logic                               xrst,
  input  logic                               reg_we,
  input  logic                               reg_re,
  input  logic [kinpira_pkg::REG_AWIDTH-1:0] reg_addr,
  input  logic [31:0]                        reg_wdata,
  input  logic                               busy,
  output logic [31:0]                        reg_rdata,
  output logic                               reg_rvalid,
  output kinpira_pkg::which_t                which,
  output logic                               start,
  output logic [IMGSIZE-1:0]                 in_offset,
  output logic [IMGSIZE-1:0]                 out_offset,
  output logic [NETSIZE-1:0]                 net_offset,
  output logic [LWIDTH-1:0]                  total_out,
  output logic [LWIDTH-1:0]                  total_in
);

  logic                req_hit;
  kinpira_pkg::which_t r_which;

  assign req_hit = reg_we && reg_addr == kinpira_pkg::REG_REQ && reg_wdata[0];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      which      <= kinpira_pkg::WHICH_HOST;
      in_offset  <= '0;
      out_offset <= '0;
      net_offset <= '0;
      total_out  <= '0;
      total_in   <= '0;
    end else if (reg_we) begin
      case (reg_addr)
        kinpira_pkg::REG_WHICH:      which      <= kinpira_pkg::which_t'(reg_wdata[1:0]);
        kinpira_pkg::REG_IN_OFFSET:  in_offset  <= reg_wdata[IMGSIZE-1:0];
        kinpira_pkg::REG_OUT_OFFSET: out_offset <= reg_wdata[IMGSIZE-1:0];
        kinpira_pkg::REG_NET_OFFSET: net_offset <= reg_wdata[NETSIZE-1:0];
        kinpira_pkg::REG_TOTAL_OUT:  total_out  <= reg_wdata[LWIDTH-1:0];
        kinpira_pkg::REG_TOTAL_IN:   total_in   <= reg_wdata[LWIDTH-1:0];
        default: ;
      endcase
    end
  end

  // Only the engine owner may kick a layer, one pulse per request
  always_ff @(posedge clk) begin
    if (!xrst) begin
      start <= 1'b0;
    end else begin
      start <= req_hit && which == kinpira_pkg::WHICH_GOBOU && !busy && !start;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      reg_rvalid <= 1'b0;
      r_which    <= kinpira_pkg::WHICH_HOST;
    end else begin
      reg_rvalid <= reg_re;
      r_which    <= which;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_re) begin
      case (reg_addr)
        kinpira_pkg::REG_WHICH:      reg_rdata <= {30'd0, which};
        kinpira_pkg::REG_IN_OFFSET:  reg_rdata <= 32'(in_offset);
        kinpira_pkg::REG_OUT_OFFSET: reg_rdata <= 32'(out_offset);
        kinpira_pkg::REG_NET_OFFSET: reg_rdata <= 32'(net_offset);
        kinpira_pkg::REG_TOTAL_OUT:  reg_rdata <= 32'(total_out);
        kinpira_pkg::REG_TOTAL_IN:   reg_rdata <= 32'(total_in);
        kinpira_pkg::REG_STATUS:     reg_rdata <= {29'd0, r_which, ~busy};
        default:                     reg_rdata <= '0;
      endcase
    end
  end

  // Engine never sees a second kick mid-layer
  start_while_busy: assert property (@(posedge clk) disable iff (!xrst)
    !(start && busy));

endmodule

// ==== hw/mem_sp.sv ====
`timescale 1ns/10ps

module mem_sp #(
  parameter int DWIDTH  = kinpira_pkg::DWIDTH,
  parameter int IMGSIZE = kinpira_pkg::IMGSIZE
) (
  input  logic               clk,
  input  logic               mem_we,
  input  logic [IMGSIZE-1:0] mem_addr,
  input  logic [DWIDTH-1:0]  mem_wdata,
  output logic [DWIDTH-1:0]  mem_rdata
);

  logic [DWIDTH-1:0] mem [2**IMGSIZE];

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
  end

  // Registered read, old data on a same-address write
  always_ff @(posedge clk) begin
    mem_rdata <= mem[mem_addr];
  end

endmodule

// ==== hw/img_mem_arbiter.sv ====
`timescale 1ns/10ps

module img_mem_arbiter #(
  parameter int DWIDTH  = kinpira_pkg::DWIDTH,
  parameter int IMGSIZE = kinpira_pkg::IMGSIZE
) (
  input  logic                clk,
  input  kinpira_pkg::which_t which,
  input  logic                img_we,
  input  logic [IMGSIZE-1:0]  img_addr,
  input  logic [31:0]         img_wdata,
  input  logic                eng_mem_we,
  input  logic [IMGSIZE-1:0]  eng_mem_addr,
  input  logic [DWIDTH-1:0]   eng_mem_wdata,
  output logic [31:0]         img_rdata,
  output logic [DWIDTH-1:0]   eng_mem_rdata
);

  logic               host_sel;
  logic               eng_sel;
  logic               mem_we;
  logic [IMGSIZE-1:0] mem_addr;
  logic [DWIDTH-1:0]  mem_wdata;
  logic [DWIDTH-1:0]  mem_rdata;

  assign host_sel = which == kinpira_pkg::WHICH_HOST;
  assign eng_sel  = which == kinpira_pkg::WHICH_GOBOU;

  // Unselected side still drives nothing into the array
  always_comb begin
    if (eng_sel) begin
      mem_we    = eng_mem_we;
      mem_addr  = eng_mem_addr;
      mem_wdata = eng_mem_wdata;
    end else begin
      mem_we    = host_sel && img_we;
      mem_addr  = img_addr;
      mem_wdata = img_wdata[DWIDTH-1:0];
    end
  end

  assign img_rdata     = {{(32-DWIDTH){mem_rdata[DWIDTH-1]}}, mem_rdata};
  assign eng_mem_rdata = mem_rdata;

  mem_sp #(
    .DWIDTH  (DWIDTH),
    .IMGSIZE (IMGSIZE)
  ) mem_img (
    .clk       (clk),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  // Engine only writes back while it owns the memory
  eng_write_owner: assert property (@(posedge clk)
    eng_mem_we |-> which == kinpira_pkg::WHICH_GOBOU);

endmodule

// ==== hw/gobou_engine.sv ====
`timescale 1ns/10ps

module gobou_engine #(
  parameter int DWIDTH  = kinpira_pkg::DWIDTH,
  parameter int IMGSIZE = kinpira_pkg::IMGSIZE,
  parameter int NETSIZE = kinpira_pkg::NETSIZE,
  parameter int LWIDTH  = kinpira_pkg::LWIDTH
) (
  input  logic                     clk,
  input  logic                     xrst,
  input  logic                     start,
  input  logic [IMGSIZE-1:0]       in_offset,
  input  logic [IMGSIZE-1:0]       out_offset,
  input  logic [NETSIZE-1:0]       net_offset,
  input  logic [LWIDTH-1:0]        total_out,
  input  logic [LWIDTH-1:0]        total_in,
  input  logic                     net_we,
  input  logic [NETSIZE-1:0]       net_addr,
  input  logic signed [DWIDTH-1:0] net_wdata,
  input  logic signed [DWIDTH-1:0] eng_mem_rdata,
  output logic                     busy,
  output logic                     eng_mem_we,
  output logic [IMGSIZE-1:0]       eng_mem_addr,
  output logic [DWIDTH-1:0]        eng_mem_wdata
);

  // Room for a full product per input plus growth over total_in terms
  localparam int AWIDTH = 2*DWIDTH + LWIDTH;
  localparam logic signed [AWIDTH-1:0] ACC_MAX =
    {{(AWIDTH-DWIDTH+1){1'b0}}, {(DWIDTH-1){1'b1}}};

  kinpira_pkg::gobou_state_t state;

  logic [LWIDTH-1:0]          out_idx;
  logic [LWIDTH-1:0]          in_idx;
  logic                       last_in;
  logic                       last_out;
  logic                       rd_valid;
  logic [NETSIZE-1:0]         w_base;
  logic [NETSIZE-1:0]         net_rd_addr;
  logic signed [DWIDTH-1:0]   net_mem [2**NETSIZE];
  logic signed [DWIDTH-1:0]   net_rdata;
  logic signed [2*DWIDTH-1:0] prod;
  logic signed [AWIDTH-1:0]   acc;

  assign last_in  = in_idx == total_in - 1'b1;
  assign last_out = out_idx == total_out - 1'b1;

  // Weight row of output o starts at net_offset + o * total_in
  assign net_rd_addr = w_base + NETSIZE'(in_idx);

  always_ff @(posedge clk) begin
    if (net_we) begin
      net_mem[net_addr] <= net_wdata;
    end
  end

  // Lines up with the registered image read
  always_ff @(posedge clk) begin
    net_rdata <= net_mem[net_rd_addr];
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state    <= kinpira_pkg::S_IDLE;
      out_idx  <= '0;
      in_idx   <= '0;
      rd_valid <= 1'b0;
    end else begin
      case (state)
        kinpira_pkg::S_IDLE: begin
          rd_valid <= 1'b0;
          // Empty layer shapes are not started
          if (start && total_in != '0 && total_out != '0) begin
            out_idx <= '0;
            in_idx  <= '0;
            state   <= kinpira_pkg::S_MAC;
          end
        end
        kinpira_pkg::S_MAC: begin
          rd_valid <= 1'b1;
          if (last_in) begin
            state <= kinpira_pkg::S_DRAIN;
          end else begin
            in_idx <= in_idx + 1'b1;
          end
        end
        kinpira_pkg::S_DRAIN: begin
          // Last read lands here
          rd_valid <= 1'b0;
          state    <= kinpira_pkg::S_WRITE;
        end
        kinpira_pkg::S_WRITE: begin
          in_idx <= '0;
          if (last_out) begin
            state <= kinpira_pkg::S_IDLE;
          end else begin
            out_idx <= out_idx + 1'b1;
            state   <= kinpira_pkg::S_MAC;
          end
        end
        default: state <= kinpira_pkg::S_IDLE;
      endcase
    end
  end

  assign prod = eng_mem_rdata * net_rdata;

  always_ff @(posedge clk) begin
    if (state == kinpira_pkg::S_IDLE && start) begin
      acc    <= '0;
      w_base <= net_offset;
    end else if (state == kinpira_pkg::S_WRITE) begin
      acc    <= '0;
      w_base <= w_base + NETSIZE'(total_in);
    end else if (rd_valid) begin
      acc <= acc + AWIDTH'(prod);
    end
  end

  // Saturate to the signed word, then ReLU
  always_comb begin
    if (acc[AWIDTH-1]) begin
      eng_mem_wdata = '0;
    end else if (acc > ACC_MAX) begin
      eng_mem_wdata = ACC_MAX[DWIDTH-1:0];
    end else begin
      eng_mem_wdata = acc[DWIDTH-1:0];
    end
  end

  assign busy       = state != kinpira_pkg::S_IDLE;
  assign eng_mem_we = state == kinpira_pkg::S_WRITE;

  assign eng_mem_addr = (state == kinpira_pkg::S_WRITE) ? out_offset + IMGSIZE'(out_idx)
                                                        : in_offset + IMGSIZE'(in_idx);

  mac_index_range: assert property (@(posedge clk) disable iff (!xrst)
    state == kinpira_pkg::S_MAC |-> in_idx < total_in);

endmodule

// ==== hw/kinpira_top.sv ====
`timescale 1ns/10ps

module kinpira_top #(
  parameter int DWIDTH  = kinpira_pkg::DWIDTH,
  parameter int IMGSIZE = kinpira_pkg::IMGSIZE,
  parameter int NETSIZE = kinpira_pkg::NETSIZE,
  parameter int LWIDTH  = kinpira_pkg::LWIDTH
) (
  input  logic                               clk,
  input  logic                               xrst,
  input  logic                               reg_we,
  input  logic                               reg_re,
  input  logic [kinpira_pkg::REG_AWIDTH-1:0] reg_addr,
  input  logic [31:0]                        reg_wdata,
  input  logic                               img_we,
  input  logic [IMGSIZE-1:0]                 img_addr,
  input  logic [31:0]                        img_wdata,
  input  logic                               net_we,
  input  logic [NETSIZE-1:0]                 net_addr,
  input  logic [DWIDTH-1:0]                  net_wdata,
  output logic [31:0]                        reg_rdata,
  output logic                               reg_rvalid,
  output logic [31:0]                        img_rdata
);

  kinpira_pkg::which_t which;
  logic                start;
  logic                busy;
  logic [IMGSIZE-1:0]  in_offset;
  logic [IMGSIZE-1:0]  out_offset;
  logic [NETSIZE-1:0]  net_offset;
  logic [LWIDTH-1:0]   total_out;
  logic [LWIDTH-1:0]   total_in;

  // Engine side of the image memory
  logic                eng_mem_we;
  logic [IMGSIZE-1:0]  eng_mem_addr;
  logic [DWIDTH-1:0]   eng_mem_wdata;
  logic [DWIDTH-1:0]   eng_mem_rdata;

  param_regs #(
    .IMGSIZE (IMGSIZE),
    .NETSIZE (NETSIZE),
    .LWIDTH  (LWIDTH)
  ) regs0 (
    .clk        (clk),
    .xrst       (xrst),
    .reg_we     (reg_we),
    .reg_re     (reg_re),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .busy       (busy),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid),
    .which      (which),
    .start      (start),
    .in_offset  (in_offset),
    .out_offset (out_offset),
    .net_offset (net_offset),
    .total_out  (total_out),
    .total_in   (total_in)
  );

  img_mem_arbiter #(
    .DWIDTH  (DWIDTH),
    .IMGSIZE (IMGSIZE)
  ) arb0 (
    .clk           (clk),
    .which         (which),
    .img_we        (img_we),
    .img_addr      (img_addr),
    .img_wdata     (img_wdata),
    .eng_mem_we    (eng_mem_we),
    .eng_mem_addr  (eng_mem_addr),
    .eng_mem_wdata (eng_mem_wdata),
    .img_rdata     (img_rdata),
    .eng_mem_rdata (eng_mem_rdata)
  );

  gobou_engine #(
    .DWIDTH  (DWIDTH),
    .IMGSIZE (IMGSIZE),
    .NETSIZE (NETSIZE),
    .LWIDTH  (LWIDTH)
  ) gobou0 (
    .clk           (clk),
    .xrst          (xrst),
    .start         (start),
    .in_offset     (in_offset),
    .out_offset    (out_offset),
    .net_offset    (net_offset),
    .total_out     (total_out),
    .total_in      (total_in),
    .net_we        (net_we),
    .net_addr      (net_addr),
    .net_wdata     (net_wdata),
    .eng_mem_rdata (eng_mem_rdata),
    .busy          (busy),
    .eng_mem_we    (eng_mem_we),
    .eng_mem_addr  (eng_mem_addr),
    .eng_mem_wdata (eng_mem_wdata)
  );

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic xrst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset held low for the first few edges
  initial begin
    xrst = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    xrst <= 1'b1;
  end

endmodule

// ==== dv/kinpira_tb.sv ====
`timescale 1ns/10ps

module kinpira_tb;

  localparam int DW       = kinpira_pkg::DWIDTH;
  localparam int IW       = kinpira_pkg::IMGSIZE;
  localparam int NW       = kinpira_pkg::NETSIZE;
  localparam int LW       = kinpira_pkg::LWIDTH;
  localparam int RW       = kinpira_pkg::REG_AWIDTH;
  localparam int WIN      = 64;
  localparam int N_SHAPES = 3;
  localparam logic [31:0] SEED = 32'h68fd_8d4d;

  // Layer shapes with bases inside the checked image window
  localparam int SHAPE_IN   [N_SHAPES] = '{12, 1, 6};
  localparam int SHAPE_OUT  [N_SHAPES] = '{5, 4, 1};
  localparam int SHAPE_IOFF [N_SHAPES] = '{3, 50, 25};
  localparam int SHAPE_OOFF [N_SHAPES] = '{40, 20, 60};
  localparam int SHAPE_NOFF [N_SHAPES] = '{7, 80, 100};

  localparam logic [RW-1:0] CFG_REGS [6] = '{
    kinpira_pkg::REG_WHICH, kinpira_pkg::REG_IN_OFFSET, kinpira_pkg::REG_OUT_OFFSET,
    kinpira_pkg::REG_NET_OFFSET, kinpira_pkg::REG_TOTAL_OUT, kinpira_pkg::REG_TOTAL_IN
  };
  localparam logic [RW-1:0] UNMAPPED [4] = '{kinpira_pkg::REG_REQ, 4'd7, 4'd10, 4'd14};

  logic          clk;
  logic          xrst;
  logic          reg_we;
  logic          reg_re;
  logic [RW-1:0] reg_addr;
  logic [31:0]   reg_wdata;
  logic [31:0]   reg_rdata;
  logic          reg_rvalid;
  logic          img_we;
  logic [IW-1:0] img_addr;
  logic [31:0]   img_wdata;
  logic [31:0]   img_rdata;
  logic          net_we;
  logic [NW-1:0] net_addr;
  logic [DW-1:0] net_wdata;

  // Expected contents of the image window and the weight memory
  logic [DW-1:0] img_model [WIN];
  logic [DW-1:0] net_model [2**NW];
  int checks = 0;
  int errors = 0;

  tb_clock #(.PERIOD(40), .RESET_CYCLES(4)) clk0 (.clk(clk), .xrst(xrst));

  kinpira_top #(
    .DWIDTH  (DW),
    .IMGSIZE (IW),
    .NETSIZE (NW),
    .LWIDTH  (LW)
  ) dut0 (
    .clk        (clk),
    .xrst       (xrst),
    .reg_we     (reg_we),
    .reg_re     (reg_re),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .img_we     (img_we),
    .img_addr   (img_addr),
    .img_wdata  (img_wdata),
    .net_we     (net_we),
    .net_addr   (net_addr),
    .net_wdata  (net_wdata),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid),
    .img_rdata  (img_rdata)
  );

  rvalid_one_cycle: assert property (@(posedge clk) disable iff (!xrst)
    reg_rvalid == $past(reg_re))
    else begin
      errors++;
      $display("[FAIL] %0t ns: reg_rvalid does not follow reg_re by one cycle", $time);
    end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks++;
    value_match: assert (got === exp)
      else begin
        errors++;
        $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
  endtask

  task automatic write_reg(input logic [RW-1:0] a, input logic [31:0] d);
    @(posedge clk);
    reg_we    <= 1'b1;
    reg_addr  <= a;
    reg_wdata <= d;
    @(posedge clk);
    reg_we    <= 1'b0;
  endtask

  task automatic read_reg(input logic [RW-1:0] a, output logic [31:0] d);
    @(posedge clk);
    reg_re   <= 1'b1;
    reg_addr <= a;
    @(posedge clk);
    reg_re   <= 1'b0;
    @(negedge clk);
    check_value(32'(reg_rvalid), 32'd1, "reg_rvalid");
    d = reg_rdata;
  endtask

  task automatic write_img(input int a, input logic [31:0] d);
    @(posedge clk);
    img_we    <= 1'b1;
    img_addr  <= IW'(a);
    img_wdata <= d;
    @(posedge clk);
    img_we    <= 1'b0;
  endtask

  task automatic read_img(input int a, output logic [31:0] d);
    @(posedge clk);
    img_addr <= IW'(a);
    @(posedge clk);
    // Data belongs to the address of the previous cycle
    img_addr <= IW'(a + 1);
    @(negedge clk);
    d = img_rdata;
  endtask

  task automatic write_net(input int a, input logic [DW-1:0] d);
    @(posedge clk);
    net_we    <= 1'b1;
    net_addr  <= NW'(a);
    net_wdata <= d;
    @(posedge clk);
    net_we    <= 1'b0;
  endtask

  function automatic logic [31:0] reg_mask(input logic [RW-1:0] a);
    case (a)
      kinpira_pkg::REG_WHICH:      return 32'h3;
      kinpira_pkg::REG_IN_OFFSET:  return (32'd1 << IW) - 32'd1;
      kinpira_pkg::REG_OUT_OFFSET: return (32'd1 << IW) - 32'd1;
      kinpira_pkg::REG_NET_OFFSET: return (32'd1 << NW) - 32'd1;
      kinpira_pkg::REG_TOTAL_OUT:  return (32'd1 << LW) - 32'd1;
      kinpira_pkg::REG_TOTAL_IN:   return (32'd1 << LW) - 32'd1;
      default:                     return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] sign_extend(input logic [DW-1:0] w);
    return 32'($signed(w));
  endfunction

  // Values in -256..255 so that some sums saturate
  function automatic logic [DW-1:0] small_rand();
    int v;
    v = int'($urandom_range(511)) - 256;
    return v[DW-1:0];
  endfunction

  function automatic logic [DW-1:0] relu_clamp(input longint acc);
    longint top;
    top = (longint'(1) <<< (DW - 1)) - 1;
    if (acc < 0) return '0;
    if (acc > top) return top[DW-1:0];
    return acc[DW-1:0];
  endfunction

  task automatic check_window(input string what);
    logic [31:0] d;
    for (int a = 0; a < WIN; a++) begin
      read_img(a, d);
      check_value(d, sign_extend(img_model[a]), $sformatf("%s img[%0d]", what, a));
    end
  endtask

  task automatic run_layer(input int s);
    int n_in;
    int n_out;
    longint acc;
    logic [31:0] d;
    logic [DW-1:0] w;
    n_in  = SHAPE_IN[s];
    n_out = SHAPE_OUT[s];
    for (int i = 0; i < n_in; i++) begin
      w = small_rand();
      write_img(SHAPE_IOFF[s] + i, sign_extend(w));
      img_model[SHAPE_IOFF[s] + i] = w;
    end
    for (int k = 0; k < n_in * n_out; k++) begin
      w = small_rand();
      write_net(SHAPE_NOFF[s] + k, w);
      net_model[SHAPE_NOFF[s] + k] = w;
    end
    write_reg(kinpira_pkg::REG_IN_OFFSET, 32'(SHAPE_IOFF[s]));
    write_reg(kinpira_pkg::REG_OUT_OFFSET, 32'(SHAPE_OOFF[s]));
    write_reg(kinpira_pkg::REG_NET_OFFSET, 32'(SHAPE_NOFF[s]));
    write_reg(kinpira_pkg::REG_TOTAL_OUT, 32'(n_out));
    write_reg(kinpira_pkg::REG_TOTAL_IN, 32'(n_in));
    write_reg(kinpira_pkg::REG_WHICH, 32'(kinpira_pkg::WHICH_GOBOU));
    write_reg(kinpira_pkg::REG_REQ, 32'd1);
    read_reg(kinpira_pkg::REG_STATUS, d);
    check_value(d, 32'h2, $sformatf("layer %0d status after start", s));
    do begin
      read_reg(kinpira_pkg::REG_STATUS, d);
    end while (d[0] !== 1'b1);
    check_value(d, 32'h3, $sformatf("layer %0d status when done", s));
    for (int o = 0; o < n_out; o++) begin
      acc = 0;
      for (int i = 0; i < n_in; i++) begin
        acc += longint'($signed(img_model[SHAPE_IOFF[s] + i]))
             * longint'($signed(net_model[SHAPE_NOFF[s] + o * n_in + i]));
      end
      img_model[SHAPE_OOFF[s] + o] = relu_clamp(acc);
    end
    write_reg(kinpira_pkg::REG_WHICH, 32'(kinpira_pkg::WHICH_HOST));
    check_window($sformatf("layer %0d", s));
  endtask

  // Up to four cycles per host write, engine cycle and readback
  function automatic int cycle_budget();
    int writes;
    int reads;
    int layer;
    writes = 7 + WIN + 11;
    reads  = 6 + 10 + WIN + 1 + 2 * WIN;
    layer  = 0;
    for (int s = 0; s < N_SHAPES; s++) begin
      writes += SHAPE_IN[s] * (1 + SHAPE_OUT[s]) + 8;
      reads  += WIN + 2;
      layer  += SHAPE_OUT[s] * (SHAPE_IN[s] + 3);
    end
    return 4 * (writes + layer + reads);
  endfunction

  initial begin : watchdog
    int limit;
    limit = cycle_budget();
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("checks %0d, errors %0d", checks, errors);
    $display("Regression failed");
    $finish;
  end

  initial begin : main
    logic [31:0] d;
    logic [31:0] v;
    void'($urandom(SEED));
    reg_we    <= 1'b0;
    reg_re    <= 1'b0;
    reg_addr  <= '0;
    reg_wdata <= '0;
    img_we    <= 1'b0;
    img_addr  <= '0;
    img_wdata <= '0;
    net_we    <= 1'b0;
    net_addr  <= '0;
    net_wdata <= '0;
    wait (xrst === 1'b1);

    read_reg(kinpira_pkg::REG_STATUS, d);
    check_value(d, 32'h1, "status after reset");
    foreach (CFG_REGS[k]) begin
      read_reg(CFG_REGS[k], d);
      check_value(d, 32'd0, $sformatf("reset value of reg %0d", CFG_REGS[k]));
    end

    foreach (CFG_REGS[k]) begin
      v = $urandom;
      write_reg(CFG_REGS[k], v);
      read_reg(CFG_REGS[k], d);
      check_value(d, v & reg_mask(CFG_REGS[k]), $sformatf("readback of reg %0d", CFG_REGS[k]));
    end
    write_reg(kinpira_pkg::REG_WHICH, 32'(kinpira_pkg::WHICH_HOST));
    foreach (UNMAPPED[k]) begin
      read_reg(UNMAPPED[k], d);
      check_value(d, 32'd0, $sformatf("unmapped reg %0d", UNMAPPED[k]));
    end

    for (int a = 0; a < WIN; a++) begin
      v = $urandom;
      write_img(a, v);
      img_model[a] = v[DW-1:0];
    end
    check_window("host image");

    for (int s = 0; s < N_SHAPES; s++) begin
      run_layer(s);
    end

    // Host side locked out while the engine owns the memory
    write_reg(kinpira_pkg::REG_WHICH, 32'(kinpira_pkg::WHICH_GOBOU));
    repeat (8) begin
      write_img(int'($urandom_range(WIN - 1)), $urandom);
    end
    write_reg(kinpira_pkg::REG_WHICH, 32'(kinpira_pkg::WHICH_HOST));
    check_window("after engine-owned host writes");
    write_reg(kinpira_pkg::REG_REQ, 32'd1);
    read_reg(kinpira_pkg::REG_STATUS, d);
    check_value(d, 32'h1, "status after request under host ownership");
    check_window("after host-owned request");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
hw/kinpira_pkg.sv
hw/param_regs.sv
hw/mem_sp.sv
hw/img_mem_arbiter.sv
hw/gobou_engine.sv
hw/kinpira_top.sv
dv/tb_clock.sv
dv/kinpira_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the kinpira testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module kinpira_tb -f list.f -o kinpira_sim; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/kinpira_sim)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1
